//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/control.sv
`timescale 1ns/1ps

module control (
    input  isa_pkg::instr_u  instr,
    output core_pkg::ctrl_t  ctrl,
    output logic             illegal
);

    import isa_pkg::*;
    import core_pkg::*;

    always_comb begin
        ctrl    = '0;
        illegal = 1'b0;
        case (instr.r.opcode)
            op_halt: ctrl.halt = 1'b1;
            op_nop:  ;
            op_addi, op_subi, op_xori, op_andni: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_wr  = 1'b1;
                ctrl.dst_sel = dst_i1_rd;
                ctrl.alu_op  = alu_op_t'(instr.r.opcode[1:0]); // Same order as the ALU ops.
                ctrl.ext_op  = instr.r.opcode[1] ? ext_z5 : ext_s5;
            end
            op_rfmt: begin
                ctrl.reg_wr  = 1'b1;
                ctrl.dst_sel = dst_r_rd;
                case (instr.r.func)
                    fn_add:  ctrl.alu_op = alu_add;
                    fn_sub:  ctrl.alu_op = alu_sub;
                    fn_xor:  ctrl.alu_op = alu_xor;
                    default: ctrl.alu_op = alu_andn;
                endcase
            end
            op_ld: begin
                ctrl.use_imm = 1'b1;
                ctrl.ext_op  = ext_s5;
                ctrl.reg_wr  = 1'b1;
                ctrl.dst_sel = dst_i1_rd;
                ctrl.mem_rd  = 1'b1;
            end
            op_st: begin
                ctrl.use_imm = 1'b1;
                ctrl.ext_op  = ext_s5;
                ctrl.mem_wr  = 1'b1;
            end
            op_lbi: begin
                ctrl.use_imm = 1'b1;
                ctrl.ext_op  = ext_s8;
                ctrl.reg_wr  = 1'b1;
                ctrl.dst_sel = dst_i2_rs;
                ctrl.lbi     = 1'b1;
            end
            op_beqz: begin
                ctrl.ext_op = ext_s8;
                ctrl.br     = 1'b1;
            end
            op_bnez: begin
                ctrl.ext_op = ext_s8;
                ctrl.br     = 1'b1;
                ctrl.br_nz  = 1'b1;
            end
            default: illegal = 1'b1;   // Anything else stops the core.
        endcase
    end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

    import isa_pkg::*;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_xor, alu_andn} alu_op_t;

    typedef enum logic [1:0] {ext_s5, ext_z5, ext_s8} ext_op_t;

    // Which instruction field names the destination register.
    typedef enum logic [1:0] {dst_r_rd, dst_i1_rd, dst_i2_rs} dst_sel_t;

    typedef struct packed {
        alu_op_t  alu_op;
        ext_op_t  ext_op;
        logic     use_imm;   // Immediate goes to the second ALU operand.
        logic     reg_wr;
        dst_sel_t dst_sel;
        logic     mem_rd;
        logic     mem_wr;
        logic     br;
        logic     br_nz;     // Branch when rs is nonzero.
        logic     lbi;
        logic     halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [word_w-1:0]    rs_val;
        logic [word_w-1:0]    rt_val;    // Store data.
        logic [word_w-1:0]    oprnd_2;
        logic [word_w-1:0]    imm;
        logic [reg_idx_w-1:0] dst;
    } dec_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [word_w-1:0] adr;
        logic [word_w-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [word_w-1:0] dat_r;
    } wb_rsp_t;

endpackage

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic              clk,
    input  logic              rst,
    output core_pkg::wb_req_t ibus_req,
    input  core_pkg::wb_rsp_t ibus_rsp,
    output core_pkg::wb_req_t dbus_req,
    input  core_pkg::wb_rsp_t dbus_rsp,
    output logic              halted,
    output logic              err
);

    import isa_pkg::*;
    import core_pkg::*;

    instr_u               instr;
    logic                 instr_valid;
    logic [word_w-1:0]    pc_next;
    dec_t                 dec;
    logic                 illegal;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_reg;
    logic [word_w-1:0]    wr_data;
    logic                 done;
    logic                 redirect;
    logic [word_w-1:0]    target;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .done        (done),
        .redirect    (redirect),
        .target      (target),
        .stop        (halted),      // No fetch once the core has stopped.
        .ibus_req    (ibus_req),
        .ibus_rsp    (ibus_rsp),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc_next     (pc_next)
    );

    decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .wr_en   (wr_en),
        .wr_reg  (wr_reg),
        .wr_data (wr_data),
        .dec     (dec),
        .illegal (illegal)
    );

    execute_mem u_exec (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .illegal     (illegal),
        .instr_valid (instr_valid),
        .pc_next     (pc_next),
        .dbus_req    (dbus_req),
        .dbus_rsp    (dbus_rsp),
        .wr_en       (wr_en),
        .wr_reg      (wr_reg),
        .wr_data     (wr_data),
        .done        (done),
        .redirect    (redirect),
        .target      (target),
        .halted      (halted),
        .err         (err)
    );

endmodule

//--- hdl/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                          clk,
    input  logic                          rst,
    input  isa_pkg::instr_u               instr,
    input  logic                          wr_en,
    input  logic [isa_pkg::reg_idx_w-1:0] wr_reg,
    input  logic [isa_pkg::word_w-1:0]    wr_data,
    output core_pkg::dec_t                dec,
    output logic                          illegal
);

    import isa_pkg::*;
    import core_pkg::*;

    ctrl_t                ctrl;
    logic [word_w-1:0]    rd_data_1;
    logic [word_w-1:0]    rd_data_2;

    reg_file u_regs (
        .clk       (clk),
        .rst       (rst),
        .rd_reg_1  (instr.r.rs),
        .rd_reg_2  (instr.r.rt),   // Bits 7 to 5 also hold the ST data register.
        .wr_reg    (wr_reg),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    control u_ctrl (
        .instr   (instr),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    always_comb begin
        case (ctrl.ext_op)
            ext_s5:  dec.imm = {{(word_w-5){instr.i1.imm5[4]}}, instr.i1.imm5};
            ext_z5:  dec.imm = {{(word_w-5){1'b0}}, instr.i1.imm5};
            ext_s8:  dec.imm = {{(word_w-8){instr.i2.imm8[7]}}, instr.i2.imm8};
            default: dec.imm = '0;
        endcase
    end

    always_comb begin
        case (ctrl.dst_sel)
            dst_r_rd:  dec.dst = instr.r.rd;
            dst_i1_rd: dec.dst = instr.i1.rd;
            dst_i2_rs: dec.dst = instr.i2.rs;
            default:   dec.dst = '0;
        endcase
    end

    assign dec.ctrl    = ctrl;
    assign dec.rs_val  = rd_data_1;
    assign dec.rt_val  = rd_data_2;
    assign dec.oprnd_2 = ctrl.use_imm ? dec.imm : rd_data_2;

endmodule

//--- hdl/execute_mem.sv
`timescale 1ns/1ps

module execute_mem (
    input  logic                          clk,
    input  logic                          rst,
    input  core_pkg::dec_t                dec,
    input  logic                          illegal,
    input  logic                          instr_valid,
    input  logic [isa_pkg::word_w-1:0]    pc_next,
    output core_pkg::wb_req_t             dbus_req,
    input  core_pkg::wb_rsp_t             dbus_rsp,
    output logic                          wr_en,
    output logic [isa_pkg::reg_idx_w-1:0] wr_reg,
    output logic [isa_pkg::word_w-1:0]    wr_data,
    output logic                          done,
    output logic                          redirect,
    output logic [isa_pkg::word_w-1:0]    target,
    output logic                          halted,
    output logic                          err
);

    import isa_pkg::*;
    import core_pkg::*;

    typedef enum logic [1:0] {x_idle, x_exec, x_mem, x_halt} state_t;

    state_t            state;
    logic [word_w-1:0] alu_res;
    logic              in_mem;
    logic              mem_ack;
    logic              rs_zero;

    always_comb begin
        case (dec.ctrl.alu_op)
            alu_add:  alu_res = dec.rs_val + dec.oprnd_2;
            alu_sub:  alu_res = dec.oprnd_2 - dec.rs_val;  // Source is the subtrahend.
            alu_xor:  alu_res = dec.rs_val ^ dec.oprnd_2;
            alu_andn: alu_res = dec.rs_val & ~dec.oprnd_2;
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= x_idle;
            err   <= 1'b0;
        end else begin
            case (state)
                x_idle: if (instr_valid) begin
                    if (illegal) begin
                        state <= x_halt;
                        err   <= 1'b1;
                    end else if (dec.ctrl.halt) begin
                        state <= x_halt;
                    end else if (dec.ctrl.mem_rd || dec.ctrl.mem_wr) begin
                        state <= x_mem;
                    end else begin
                        state <= x_exec;
                    end
                end
                x_exec:  state <= x_idle;
                x_mem:   if (dbus_rsp.ack) state <= x_idle;
                x_halt:  state <= x_halt;   // Only reset leaves here.
                default: state <= x_idle;
            endcase
        end
    end

    assign in_mem  = (state == x_mem);
    assign mem_ack = in_mem & dbus_rsp.ack;
    assign rs_zero = (dec.rs_val == '0);

    assign dbus_req.cyc   = in_mem;
    assign dbus_req.stb   = in_mem;
    assign dbus_req.we    = in_mem & dec.ctrl.mem_wr;
    assign dbus_req.adr   = dec.rs_val + dec.imm;
    assign dbus_req.dat_w = dec.rt_val;

    assign done     = (state == x_exec) | mem_ack;
    assign wr_en    = dec.ctrl.reg_wr & done;  // ST has no reg_wr.
    assign wr_reg   = dec.dst;
    assign wr_data  = dec.ctrl.lbi ? dec.imm : (dec.ctrl.mem_rd ? dbus_rsp.dat_r : alu_res);
    assign redirect = (state == x_exec) & dec.ctrl.br & (rs_zero ^ dec.ctrl.br_nz);
    assign target   = pc_next + dec.imm;
    assign halted   = (state == x_halt);

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       done,
    input  logic                       redirect,
    input  logic [isa_pkg::word_w-1:0] target,
    input  logic                       stop,
    output core_pkg::wb_req_t          ibus_req,
    input  core_pkg::wb_rsp_t          ibus_rsp,
    output isa_pkg::instr_u            instr,
    output logic                       instr_valid,
    output logic [isa_pkg::word_w-1:0] pc_next
);

    import isa_pkg::*;
    import core_pkg::*;

    typedef enum logic {f_idle, f_busy} state_t;

    state_t            state;
    logic [word_w-1:0] pc;
    logic              kick;    // High for one cycle after reset.
    logic              start;

    assign pc_next = pc + 1'b1;
    assign start   = (kick | done) & ~stop;

    assign ibus_req.cyc   = (state == f_busy);
    assign ibus_req.stb   = (state == f_busy);
    assign ibus_req.we    = 1'b0;           // Instruction bus is read only.
    assign ibus_req.adr   = pc;
    assign ibus_req.dat_w = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= f_idle;
            pc          <= '0;
            kick        <= 1'b1;
            instr_valid <= 1'b0;
        end else begin
            kick        <= 1'b0;
            instr_valid <= 1'b0;
            if (done) begin
                pc <= redirect ? target : pc_next;
            end
            case (state)
                f_idle: if (start) state <= f_busy;
                f_busy: if (ibus_rsp.ack) begin
                    state       <= f_idle;
                    instr_valid <= 1'b1;
                end
                default: state <= f_idle;
            endcase
        end
    end

    // Instruction register holds until the next fetch completes.
    always_ff @(posedge clk) begin
        if (state == f_busy && ibus_rsp.ack) begin
            instr <= ibus_rsp.dat_r;
        end
    end

endmodule

//--- hdl/isa_pkg.sv
package isa_pkg;

    localparam int word_w    = 16;
    localparam int reg_cnt   = 8;
    localparam int reg_idx_w = $clog2(reg_cnt);

    // Major opcodes live in instr[15:11].
    typedef enum logic [4:0] {
        op_halt  = 5'b00000,
        op_nop   = 5'b00001,
        op_addi  = 5'b01000,
        op_subi  = 5'b01001,
        op_xori  = 5'b01010,
        op_andni = 5'b01011,
        op_beqz  = 5'b01100,
        op_bnez  = 5'b01101,
        op_st    = 5'b10000,
        op_ld    = 5'b10001,
        op_lbi   = 5'b11000,
        op_rfmt  = 5'b11011   // Register ALU group, func picks the operation.
    } opcode_t;

    typedef enum logic [1:0] {
        fn_add  = 2'd0,
        fn_sub  = 2'd1,
        fn_xor  = 2'd2,
        fn_andn = 2'd3
    } func_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [reg_idx_w-1:0]   rs;
        logic [reg_idx_w-1:0]   rt;
        logic [reg_idx_w-1:0]   rd;
        func_t                  func;
    } r_fmt_t;

    // For ST the rd slot names the register holding the store data.
    typedef struct packed {
        opcode_t                opcode;
        logic [reg_idx_w-1:0]   rs;
        logic [reg_idx_w-1:0]   rd;
        logic [4:0]             imm5;
    } i1_fmt_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [reg_idx_w-1:0]   rs;
        logic [7:0]             imm8;
    } i2_fmt_t;

    // One instruction word, three views of it.
    typedef union packed {
        r_fmt_t  r;
        i1_fmt_t i1;
        i2_fmt_t i2;
    } instr_u;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [isa_pkg::reg_idx_w-1:0] rd_reg_1,
    input  logic [isa_pkg::reg_idx_w-1:0] rd_reg_2,
    input  logic [isa_pkg::reg_idx_w-1:0] wr_reg,
    input  logic                          wr_en,
    input  logic [isa_pkg::word_w-1:0]    wr_data,
    output logic [isa_pkg::word_w-1:0]    rd_data_1,
    output logic [isa_pkg::word_w-1:0]    rd_data_2
);

    import isa_pkg::*;

    logic [word_w-1:0] regs [reg_cnt];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_cnt; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // No bypass, a read in the write cycle returns the old value.
    assign rd_data_1 = regs[rd_reg_1];
    assign rd_data_2 = regs[rd_reg_2];

endmodule

//--- src.f
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/control.sv
hdl/fetch_unit.sv
hdl/decode.sv
hdl/execute_mem.sv
hdl/cpu_top.sv
tb/cpu_chk.sv
tb/tb_cpu.sv

//--- tb/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
    input logic              clk,
    input logic              rst,
    input core_pkg::wb_req_t ibus_req,
    input core_pkg::wb_rsp_t ibus_rsp,
    input core_pkg::wb_req_t dbus_req,
    input core_pkg::wb_rsp_t dbus_rsp,
    input logic              halted
);

    a_istb_cyc: assert property (@(posedge clk) disable iff (rst)
        ibus_req.stb |-> ibus_req.cyc) else $error("ibus stb without cyc");

    a_dstb_cyc: assert property (@(posedge clk) disable iff (rst)
        dbus_req.stb |-> dbus_req.cyc) else $error("dbus stb without cyc");

    // Request must hold until the slave acks.
    a_ihold: assert property (@(posedge clk) disable iff (rst)
        ibus_req.stb && !ibus_rsp.ack |=> $stable({ibus_req.adr, ibus_req.we, ibus_req.dat_w}))
        else $error("ibus request changed while waiting for ack");

    a_dhold: assert property (@(posedge clk) disable iff (rst)
        dbus_req.stb && !dbus_rsp.ack |=> $stable({dbus_req.adr, dbus_req.we, dbus_req.dat_w}))
        else $error("dbus request changed while waiting for ack");

    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        halted |-> !ibus_req.cyc && !dbus_req.cyc) else $error("bus cycle after halt");

    a_rst_idle: assert property (@(posedge clk)
        $fell(rst) |-> !ibus_req.cyc && !dbus_req.cyc) else $error("bus busy after reset");

endmodule

bind cpu_top cpu_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp),
    .dbus_req (dbus_req),
    .dbus_rsp (dbus_rsp),
    .halted   (halted)
);

//--- tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    import isa_pkg::*;
    import core_pkg::*;

    localparam int n_tests   = 12;
    localparam int max_instr = 64;
    localparam int max_cyc   = n_tests * max_instr * 12;

    logic    clk;
    logic    rst;
    wb_req_t ibus_req;
    wb_rsp_t ibus_rsp;
    wb_req_t dbus_req;
    wb_rsp_t dbus_rsp;
    logic    halted;
    logic    err;

    logic [word_w-1:0] imem  [256];
    logic [word_w-1:0] dmem  [256];
    logic [word_w-1:0] mdmem [256];   // Data memory as the model sees it.
    wb_req_t           exp_fetch [$];
    wb_req_t           exp_store [$];
    logic              exp_halted;
    logic              exp_err;
    int                i_wait;
    int                d_wait;
    int                cycles = 0;
    int                test_errs;
    int                pass_cnt;
    int                fail_cnt;

    cpu_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp),
        .halted   (halted),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_fetch(input wb_req_t got);
        wb_req_t exp;
        if (exp_fetch.size() == 0) begin
            $display("Unexpected fetch from address %h after the program stopped", got.adr);
            test_errs++;
        end else begin
            exp = exp_fetch.pop_front();
            if (got.we !== exp.we || got.adr !== exp.adr) begin
                $display("ERROR %0t: fetch adr %h we %b, expected adr %h we %b",
                         $time, got.adr, got.we, exp.adr, exp.we);
                test_errs++;
            end
        end
    endtask

    task automatic check_store(input wb_req_t got);
        wb_req_t exp;
        if (exp_store.size() == 0) begin
            $display("Unexpected store to address %h that the program never makes", got.adr);
            test_errs++;
        end else begin
            exp = exp_store.pop_front();
            if (got.adr !== exp.adr || got.dat_w !== exp.dat_w) begin
                $display("ERROR %0t: store %h to %h, expected %h to %h",
                         $time, got.dat_w, got.adr, exp.dat_w, exp.adr);
                test_errs++;
            end
        end
    endtask

    task automatic check_status(input logic got_h, input logic got_e,
                                input logic want_h, input logic want_e);
        if (got_h !== want_h || got_e !== want_e) begin
            $display("ERROR %0t: halted %b err %b, expected halted %b err %b",
                     $time, got_h, got_e, want_h, want_e);
            test_errs++;
        end
    endtask

    // Slave side of both buses with 0 to 3 wait states per transfer.
    task automatic serve_ibus();
        if (ibus_rsp.ack) begin
            ibus_rsp.ack <= 1'b0;
            i_wait = -1;
        end else if (ibus_req.cyc && ibus_req.stb) begin
            if (i_wait < 0) begin
                i_wait = $urandom_range(0, 3);
            end
            if (i_wait > 0) begin
                i_wait--;
            end else begin
                ibus_rsp.ack   <= 1'b1;
                ibus_rsp.dat_r <= imem[ibus_req.adr[7:0]];
                check_fetch(ibus_req);
            end
        end
    endtask

    task automatic serve_dbus();
        if (dbus_rsp.ack) begin
            dbus_rsp.ack <= 1'b0;
            d_wait = -1;
        end else if (dbus_req.cyc && dbus_req.stb) begin
            if (d_wait < 0) begin
                d_wait = $urandom_range(0, 3);
            end
            if (d_wait > 0) begin
                d_wait--;
            end else begin
                dbus_rsp.ack <= 1'b1;
                if (dbus_req.we) begin
                    dmem[dbus_req.adr[7:0]] = dbus_req.dat_w;
                    check_store(dbus_req);
                end else begin
                    dbus_rsp.dat_r <= dmem[dbus_req.adr[7:0]];
                end
            end
        end
    endtask

    initial begin
        ibus_rsp = '0;
        dbus_rsp = '0;
        i_wait   = -1;
        d_wait   = -1;
        forever begin
            @(negedge clk);
            if (rst !== 1'b0) begin
                ibus_rsp.ack <= 1'b0;
                dbus_rsp.ack <= 1'b0;
                i_wait = -1;
                d_wait = -1;
            end else begin
                serve_ibus();
                serve_dbus();
            end
        end
    end

    function automatic bit is_legal(input logic [4:0] op);
        case (op)
            5'b00000, 5'b00001, 5'b01000, 5'b01001, 5'b01010, 5'b01011,
            5'b01100, 5'b01101, 5'b10000, 5'b10001, 5'b11000, 5'b11011: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic gen_program(input bit with_bad);
        instr_u     ins;
        logic [4:0] bad_op;
        int         body;
        int         bad_pos;
        body    = $urandom_range(24, 48);
        bad_pos = with_bad ? $urandom_range(2, body - 1) : -1;
        for (int a = 0; a < 256; a++) begin
            imem[a] = {op_halt, 3'b000, a[7:0]};   // HALT with the address in the low bits.
            dmem[a] = 16'($urandom());
        end
        for (int pc = 0; pc < body; pc++) begin
            ins = 16'($urandom());
            case ($urandom_range(0, 9))
                0, 1, 2: ins.r.opcode = op_rfmt;
                3, 4:    ins.r.opcode = opcode_t'(5'b01000 + 5'($urandom_range(0, 3)));
                5: begin
                    ins.r.opcode = op_lbi;
                    if ($urandom_range(0, 2) == 0) ins.i2.imm8 = '0;   // Zeros feed branches.
                end
                6: ins.r.opcode = op_ld;
                7: ins.r.opcode = op_st;
                8: begin
                    ins.r.opcode = $urandom_range(0, 1) ? op_beqz : op_bnez;
                    // Forward only and never past the illegal opcode.
                    ins.i2.imm8  = 8'($urandom_range(0,
                                       ((pc < bad_pos) ? bad_pos : body) - pc - 1));
                end
                default: ins.r.opcode = op_nop;
            endcase
            if (pc == bad_pos) begin
                do begin
                    bad_op = 5'($urandom());
                end while (is_legal(bad_op));
                ins.r.opcode = opcode_t'(bad_op);
            end
            imem[pc] = ins;
        end
        // Dump every register relative to r0 and then stop.
        for (int r = 0; r < reg_cnt; r++) begin
            ins           = '0;
            ins.i1.opcode = op_st;
            ins.i1.rd     = 3'(r);
            ins.i1.imm5   = 5'(r);
            imem[body + r] = ins;
        end
        imem[body + reg_cnt] = '0;
    endtask

    // Instruction-set model that fills the expected fetch and store queues.
    task automatic run_model();
        logic [word_w-1:0] regs [reg_cnt];
        logic [word_w-1:0] pc;
        logic [word_w-1:0] a;
        logic [word_w-1:0] b;
        logic [word_w-1:0] s5;
        logic [word_w-1:0] z5;
        logic [word_w-1:0] s8;
        instr_u            ins;
        wb_req_t           req;
        bit                stop;
        for (int r = 0; r < reg_cnt; r++) begin
            regs[r] = '0;
        end
        pc         = '0;
        stop       = 1'b0;
        exp_halted = 1'b0;
        exp_err    = 1'b0;
        for (int n = 0; n < 256 && !stop; n++) begin
            ins     = imem[pc[7:0]];
            req     = '0;
            req.cyc = 1'b1;
            req.stb = 1'b1;
            req.adr = pc;
            exp_fetch.push_back(req);
            a  = regs[ins.r.rs];
            b  = regs[ins.r.rt];
            s5 = {{11{ins.i1.imm5[4]}}, ins.i1.imm5};
            z5 = {11'b0, ins.i1.imm5};
            s8 = {{8{ins.i2.imm8[7]}}, ins.i2.imm8};
            pc = pc + 16'd1;
            case (ins.r.opcode)
                op_halt: begin
                    exp_halted = 1'b1;
                    stop       = 1'b1;
                end
                op_nop:   ;
                op_addi:  regs[ins.i1.rd] = a + s5;
                op_subi:  regs[ins.i1.rd] = s5 - a;
                op_xori:  regs[ins.i1.rd] = a ^ z5;
                op_andni: regs[ins.i1.rd] = a & ~z5;
                op_rfmt: begin
                    case (ins.r.func)
                        fn_add:  regs[ins.r.rd] = a + b;
                        fn_sub:  regs[ins.r.rd] = b - a;
                        fn_xor:  regs[ins.r.rd] = a ^ b;
                        default: regs[ins.r.rd] = a & ~b;
                    endcase
                end
                op_ld: begin
                    req.adr         = a + s5;
                    regs[ins.i1.rd] = mdmem[req.adr[7:0]];
                end
                op_st: begin
                    req.we    = 1'b1;
                    req.adr   = a + s5;
                    req.dat_w = regs[ins.i1.rd];
                    exp_store.push_back(req);
                    mdmem[req.adr[7:0]] = req.dat_w;
                end
                op_lbi:  regs[ins.i2.rs] = s8;
                op_beqz: if (a == '0) pc = pc + s8;
                op_bnez: if (a != '0) pc = pc + s8;
                default: begin
                    exp_halted = 1'b1;
                    exp_err    = 1'b1;
                    stop       = 1'b1;
                end
            endcase
        end
    endtask

    // Holds reset 4 cycles and restarts the model from the current data memory.
    task automatic reset_dut();
        @(negedge clk);
        rst <= 1'b1;
        repeat (4) @(negedge clk);
        exp_fetch.delete();
        exp_store.delete();
        mdmem = dmem;
        run_model();
        check_status(halted, err, 1'b0, 1'b0);
        rst <= 1'b0;
    endtask

    task automatic run_test(input int t);
        test_errs = 0;
        gen_program(t % 4 == 3);
        reset_dut();
        if (t % 4 == 1) begin
            repeat ($urandom_range(20, 120)) @(negedge clk);
            reset_dut();   // Mid-program restart.
        end
        while (!halted) @(negedge clk);
        repeat (10) @(negedge clk);
        if (exp_fetch.size() != 0) begin
            $display("Test %0d: %0d expected fetches never happened", t, exp_fetch.size());
            test_errs++;
        end
        if (exp_store.size() != 0) begin
            $display("Test %0d: %0d expected stores never happened", t, exp_store.size());
            test_errs++;
        end
        check_status(halted, err, exp_halted, exp_err);
        if (test_errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Test %0d %s, err %b, %0d errors", t, (test_errs == 0) ? "ok" : "bad",
                 exp_err, test_errs);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cyc) begin
            $display("Timeout after %0d cycles, the core never finished its programs", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(61));
        rst      <= 1'b1;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
